//--- files.f
eth_rx_pkg.sv
eth_mii_rx.sv
eth_crc32.sv
eth_rx_buffer.sv
eth_rx_regs.sv
eth_rx_core.sv
tb_eth_rx.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -j 0 --top-module tb_eth_rx \
      -f files.f -o tb_eth_rx \
   && ./obj_dir/tb_eth_rx \
   || { echo "simulation did not pass"; exit 1; }

//--- tb_eth_rx.sv
module tb_eth_rx
   import eth_rx_pkg::*;
();

   localparam logic [47:0] OWN_MAC = 48'h02_00_00_00_00_01;
   localparam int          TIMEOUT = 2000;

   logic        RX_CLK;
   logic        ETH_PHY_RESETN;
   logic [3:0]  RX_DATA;
   logic        RX_DV;
   wb_req_t     wb_in;
   wb_rsp_t     wb_out;

   logic [7:0]  frame_q[$];
   logic [7:0]  held_q[$];
   logic [31:0] lcg_state;

   eth_rx_core #(
      .ETH_MAC_ADDR (OWN_MAC),
      .BUF_ADDR_W   (9)
   ) uut (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .wb_in          (wb_in),
      .wb_out         (wb_out)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #2 RX_CLK = ~RX_CLK;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Ethernet FCS over the first n bytes, bit serial, LSB of each byte first
   function automatic logic [31:0] crc32_ref(input int n);
      logic [31:0] c;
      logic        fb;
      c = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ frame_q[i][b];
            c  = c >> 1;
            if (fb) begin
               c = c ^ 32'hEDB8_8320;
            end
         end
      end
      return ~c;
   endfunction

   // Byte 4w lands in the least significant lane
   function automatic logic [31:0] pack_word(input int w);
      return {frame_q[4*w+3], frame_q[4*w+2], frame_q[4*w+1], frame_q[4*w]};
   endfunction

   function automatic logic [31:0] status_exp(input logic rcvd, input logic ok, input int size);
      logic [31:0] w;
      w        = 32'd0;
      w[0]     = rcvd;
      w[1]     = ok;
      w[2]     = 1'b1;
      w[26:16] = size[10:0];
      return w;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic bus_cycle(input logic we, input logic [9:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output logic [31:0] rdat);
      int n;
      @(negedge RX_CLK);
      wb_in.cyc = 1'b1;
      wb_in.stb = 1'b1;
      wb_in.we  = we;
      wb_in.adr = adr;
      wb_in.sel = sel;
      wb_in.dat = dat;
      n = 0;
      do begin
         @(negedge RX_CLK);
         n++;
      end while (!wb_out.ack && n < TIMEOUT);
      if (!wb_out.ack) begin
         abort_run("Wishbone access got no ack before the timeout");
      end
      rdat  = wb_out.dat;
      wb_in = '0;
   endtask

   task automatic read_reg(input logic [9:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 4'hF, 32'd0, data);
   endtask

   task automatic write_reg(input logic [9:0] adr, input logic [3:0] sel, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, sel, data, unused);
   endtask

   task automatic build_frame(input logic [47:0] dst, input int len, input logic bad_fcs);
      logic [31:0] fcs;
      frame_q.delete();
      for (int i = 0; i < 6; i++) begin
         frame_q.push_back(dst[47-8*i -: 8]);
      end
      while (frame_q.size() < len - 4) begin
         lcg_state = lcg_next(lcg_state);
         frame_q.push_back(lcg_state[23:16]);
      end
      fcs = crc32_ref(len - 4);
      for (int i = 0; i < 4; i++) begin
         frame_q.push_back(fcs[8*i +: 8]);
      end
      if (bad_fcs) begin
         frame_q[len-2] = frame_q[len-2] ^ 8'h10;
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(negedge RX_CLK);
      RX_DV   = 1'b1;
      RX_DATA = b[3:0];
      @(negedge RX_CLK);
      RX_DATA = b[7:4];
   endtask

   task automatic send_frame();
      // Inter-frame gap
      repeat (4) begin
         @(negedge RX_CLK);
         RX_DV   = 1'b0;
         RX_DATA = 4'h0;
      end
      for (int i = 0; i < 8; i++) begin
         send_byte((i == 7) ? 8'hD5 : 8'h55);
      end
      foreach (frame_q[i]) begin
         send_byte(frame_q[i]);
      end
      @(negedge RX_CLK);
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
   endtask

   task automatic check_buffer(input string name);
      logic [31:0] v;
      for (int w = 0; w < frame_q.size() / 4; w++) begin
         read_reg(10'h200 + 10'(w), v);
         check_equal($sformatf("%s word %0d", name, w), pack_word(w), v);
      end
   endtask

   task automatic check_frame(input string name, input logic ok);
      int          n;
      logic [31:0] v;
      n = 0;
      read_reg(REG_STATUS, v);
      while (!v[0] && n < 50) begin
         read_reg(REG_STATUS, v);
         n++;
      end
      if (!v[0]) begin
         abort_run("data_rcvd never came up after a frame to an accepted address");
      end
      check_equal({name, " status"}, status_exp(1'b1, ok, frame_q.size()), v);
      read_reg(REG_CRC, v);
      check_equal({name, " crc"}, crc32_ref(frame_q.size() - 4), v);
      check_buffer({name, " buffer"});
   endtask

   initial begin
      logic [31:0] v;
      ETH_PHY_RESETN = 1'b0;
      RX_DATA        = 4'h0;
      RX_DV          = 1'b0;
      wb_in          = '0;
      lcg_state      = 32'd75;
      repeat (4) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;

      // 1: reset values
      read_reg(REG_STATUS, v);
      check_equal("t1 status", 32'd0, v);
      read_reg(REG_DUMMY, v);
      check_equal("t1 dummy", 32'd0, v);

      // 2: scratch register with byte enables
      write_reg(REG_DUMMY, 4'hF, 32'hA5C3_1E78);
      read_reg(REG_DUMMY, v);
      check_equal("t2 dummy full", 32'hA5C3_1E78, v);
      write_reg(REG_DUMMY, 4'b0101, 32'h1122_3344);
      read_reg(REG_DUMMY, v);
      check_equal("t2 dummy partial", 32'hA522_1E44, v);

      // 3: good frame to the own address
      build_frame(OWN_MAC, 64, 1'b0);
      send_frame();
      check_frame("t3 good frame", 1'b1);
      write_reg(REG_RCVACK, 4'hF, 32'd1);

      // 4: corrupted FCS
      build_frame(OWN_MAC, 64, 1'b1);
      send_frame();
      check_frame("t4 bad fcs", 1'b0);
      write_reg(REG_RCVACK, 4'hF, 32'd1);

      // 5: foreign address dropped, broadcast taken
      build_frame(48'h02_00_00_00_00_02, 64, 1'b0);
      send_frame();
      repeat (4) begin
         read_reg(REG_STATUS, v);
         check_equal("t5 foreign data_rcvd", 32'd0, {31'd0, v[0]});
      end
      build_frame(48'hFFFF_FFFF_FFFF, 64, 1'b0);
      send_frame();
      check_frame("t5 broadcast", 1'b1);

      // 6: frame while held is lost, then ack and receive again
      held_q = frame_q;
      build_frame(OWN_MAC, 80, 1'b0);
      send_frame();
      frame_q = held_q;
      read_reg(REG_STATUS, v);
      check_equal("t6 held status", status_exp(1'b1, 1'b1, 64), v);
      check_buffer("t6 held buffer");
      write_reg(REG_RCVACK, 4'hF, 32'd1);
      read_reg(REG_STATUS, v);
      check_equal("t6 status after ack", status_exp(1'b0, 1'b1, 64), v);
      build_frame(OWN_MAC, 80, 1'b0);
      send_frame();
      check_frame("t6 after ack", 1'b1);
      write_reg(REG_DUMMY, 4'hF, 32'hDEAD_BEEF);
      write_reg(REG_SOFTRST, 4'hF, 32'd1);
      read_reg(REG_STATUS, v);
      check_equal("t6 status after soft reset", 32'd0, v);
      read_reg(REG_DUMMY, v);
      check_equal("t6 dummy after soft reset", 32'd0, v);

      $display("all tests passed");
      $finish;
   end

endmodule

//--- eth_rx_core.sv
module eth_rx_core
   import eth_rx_pkg::*;
#(
   parameter logic [47:0] ETH_MAC_ADDR = 48'h02_00_00_00_00_01,
   parameter int          BUF_ADDR_W   = 9
) (
   input  logic       RX_CLK,
   input  logic       ETH_PHY_RESETN,
   input  logic [3:0] RX_DATA,
   input  logic       RX_DV,
   input  wb_req_t    wb_in,
   output wb_rsp_t    wb_out
);

   logic                  frame_start;
   logic                  byte_valid;
   logic [7:0]            byte_data;
   logic                  wr;
   logic [BUF_ADDR_W+1:0] wr_addr;
   logic [7:0]            wr_data;
   frame_status_t         status;
   logic [31:0]           crc_value;
   logic                  crc_good;
   logic                  rcv_ack;
   logic                  soft_rst;
   logic                  rd_en;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [31:0]           rd_data;

   eth_mii_rx #(
      .ETH_MAC_ADDR (ETH_MAC_ADDR),
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) u_mii_rx (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .soft_rst       (soft_rst),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .rcv_ack        (rcv_ack),
      .crc_good       (crc_good),
      .frame_start    (frame_start),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .wr             (wr),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .status         (status)
   );

   eth_crc32 u_crc32 (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .frame_start    (frame_start),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .crc_value      (crc_value),
      .crc_good       (crc_good)
   );

   eth_rx_buffer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_rx_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_rx_regs #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_rx_regs (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .wb_in          (wb_in),
      .status         (status),
      .crc_value      (crc_value),
      .rd_data        (rd_data),
      .wb_out         (wb_out),
      .rcv_ack        (rcv_ack),
      .soft_rst       (soft_rst),
      .rd_en          (rd_en),
      .rd_addr        (rd_addr)
   );

endmodule

//--- eth_rx_regs.sv
module eth_rx_regs
   import eth_rx_pkg::*;
#(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                  RX_CLK,
   input  logic                  ETH_PHY_RESETN,
   input  wb_req_t               wb_in,
   input  frame_status_t         status,
   input  logic [31:0]           crc_value,
   input  logic [31:0]           rd_data,
   output wb_rsp_t               wb_out,
   output logic                  rcv_ack,
   output logic                  soft_rst,
   output logic                  rd_en,
   output logic [BUF_ADDR_W-1:0] rd_addr
);

   logic        req;
   logic        new_req;
   logic        wr_req;
   logic        buf_sel;
   logic        ack;
   logic [31:0] dummy;
   logic [31:0] status_word;
   logic [31:0] reg_rdata;

   assign req = wb_in.cyc && wb_in.stb;
   // One ack per request, even if stb stays high
   assign new_req = req && !ack;
   assign wr_req  = new_req && wb_in.we;
   assign buf_sel = wb_in.adr[BUF_SEL_BIT];

   // Buffer read starts on the sampling edge so data lines up with ack
   assign rd_en   = new_req && !wb_in.we && buf_sel;
   assign rd_addr = wb_in.adr[BUF_ADDR_W-1:0];

   always_comb begin
      status_word                                = '0;
      status_word[ST_DATA_RCVD]                  = status.data_rcvd;
      status_word[ST_CRC_OK]                     = status.crc_ok;
      status_word[ST_DV_DETECTED]                = status.dv_detected;
      status_word[ST_SIZE_LSB +: RCV_SIZE_W]     = status.rcv_size;
   end

   // Write-only and unmapped words read as zero
   always_comb begin
      reg_rdata = '0;
      if (buf_sel) begin
         reg_rdata = rd_data;
      end else begin
         case (wb_in.adr)
            REG_STATUS: reg_rdata = status_word;
            REG_DUMMY:  reg_rdata = dummy;
            REG_CRC:    reg_rdata = crc_value;
            default:    reg_rdata = '0;
         endcase
      end
   end

   assign wb_out.ack = ack;
   assign wb_out.dat = ack ? reg_rdata : '0;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         ack     <= 1'b0;
         rcv_ack <= 1'b0;
         dummy   <= '0;
      end else if (soft_rst) begin
         ack     <= 1'b0;
         rcv_ack <= 1'b0;
         dummy   <= '0;
      end else begin
         ack     <= new_req;
         rcv_ack <= wr_req && !buf_sel && (wb_in.adr == REG_RCVACK);
         if (wr_req && !buf_sel && wb_in.adr == REG_DUMMY) begin
            for (int i = 0; i < 4; i++) begin
               if (wb_in.sel[i]) begin
                  dummy[8*i +: 8] <= wb_in.dat[8*i +: 8];
               end
            end
         end
      end
   end

   // Self-clearing soft reset, high for one cycle after the write
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= wr_req && !buf_sel && (wb_in.adr == REG_SOFTRST);
      end
   end

   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      wb_out.ack |=> !wb_out.ack);

   // No spurious ack without a master request
   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      wb_out.ack |-> $past(wb_in.cyc && wb_in.stb));

endmodule

//--- eth_rx_buffer.sv
module eth_rx_buffer #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                  RX_CLK,
   input  logic                  wr,
   input  logic [BUF_ADDR_W+1:0] wr_addr,
   input  logic [7:0]            wr_data,
   input  logic                  rd_en,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]           rd_data
);

   logic [31:0]           mem [2**BUF_ADDR_W];
   logic [3:0]            lane_we;
   logic [BUF_ADDR_W-1:0] wr_word;

   // Lane 0 is the least significant byte of the word
   assign lane_we = wr ? (4'b0001 << wr_addr[1:0]) : 4'b0000;
   assign wr_word = wr_addr[BUF_ADDR_W+1:2];

   always_ff @(posedge RX_CLK) begin
      for (int i = 0; i < 4; i++) begin
         if (lane_we[i]) begin
            mem[wr_word][8*i +: 8] <= wr_data;
         end
      end
   end

   // Bus side, one registered word per read
   always_ff @(posedge RX_CLK) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

   assert property (@(posedge RX_CLK) wr |-> !$isunknown(wr_addr));

endmodule

//--- eth_crc32.sv
module eth_crc32
   import eth_rx_pkg::*;
(
   input  logic        RX_CLK,
   input  logic        ETH_PHY_RESETN,
   input  logic        frame_start,
   input  logic        byte_valid,
   input  logic [7:0]  byte_data,
   output logic [31:0] crc_value,
   output logic        crc_good
);

   // 04C11DB7 bit-reversed, bytes enter LSB first
   localparam logic [31:0] POLY_REFL = 32'hEDB88320;

   logic [31:0]      crc_q;
   logic [3:0][31:0] crc_hist;

   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'd0, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ POLY_REFL) : (c >> 1);
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q <= '1;
      end else if (frame_start) begin
         crc_q <= '1;
      end else if (byte_valid) begin
         crc_q <= crc_byte(crc_q, byte_data);
      end
   end

   // Register value from four bytes back, the CRC without the FCS
   always_ff @(posedge RX_CLK) begin
      if (byte_valid) begin
         crc_hist <= {crc_hist[2:0], crc_q};
      end
   end

   assign crc_value = ~crc_hist[3];

   // Running over the FCS too leaves the fixed residue
   assign crc_good = (crc_q == CRC_RESIDUE);

endmodule

//--- eth_mii_rx.sv
module eth_mii_rx
   import eth_rx_pkg::*;
#(
   parameter logic [47:0] ETH_MAC_ADDR = 48'h02_00_00_00_00_01,
   parameter int          BUF_ADDR_W   = 9
) (
   input  logic                  RX_CLK,
   input  logic                  ETH_PHY_RESETN,
   input  logic                  soft_rst,
   input  logic [3:0]            RX_DATA,
   input  logic                  RX_DV,
   input  logic                  rcv_ack,
   input  logic                  crc_good,
   output logic                  frame_start,
   output logic                  byte_valid,
   output logic [7:0]            byte_data,
   output logic                  wr,
   output logic [BUF_ADDR_W+1:0] wr_addr,
   output logic [7:0]            wr_data,
   output frame_status_t         status
);

   // Preamble nibbles needed in front of the SFD nibble
   localparam logic [2:0] PRE_NIBBLES = 3'd5;

   rx_state_t             state;
   logic [2:0]            pre_cnt;
   logic                  nib_hi;
   logic [3:0]            nib_lo;
   logic [BUF_ADDR_W+1:0] byte_cnt;
   logic                  addr_own;
   logic                  addr_bcast;
   logic                  closing;
   logic [47:0]           mac_shift;
   logic [7:0]            new_byte;
   logic                  own_next;
   logic                  bcast_next;
   logic                  sfd_seen;
   logic                  byte_done;
   logic                  addr_done;

   // Port RX_DATA hides the state literal, so that one is named with its package
   assign new_byte  = {RX_DATA, nib_lo};
   assign sfd_seen  = (state == RX_PREAMBLE) && RX_DV && (RX_DATA == 4'hD) &&
                      (pre_cnt == PRE_NIBBLES);
   assign byte_done = (state == eth_rx_pkg::RX_DATA) && RX_DV && !closing && nib_hi;
   assign addr_done = (byte_cnt >= 6);

   // First destination byte on the wire is the MSB of the address
   assign mac_shift  = ETH_MAC_ADDR << {byte_cnt[2:0], 3'b000};
   assign own_next   = addr_own && (new_byte == mac_shift[47:40]);
   assign bcast_next = addr_bcast && (new_byte == 8'hFF);

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= RX_IDLE;
         pre_cnt     <= '0;
         nib_hi      <= 1'b0;
         byte_cnt    <= '0;
         addr_own    <= 1'b0;
         addr_bcast  <= 1'b0;
         closing     <= 1'b0;
         frame_start <= 1'b0;
         byte_valid  <= 1'b0;
         wr          <= 1'b0;
         status      <= '0;
      end else if (soft_rst) begin
         state       <= RX_IDLE;
         closing     <= 1'b0;
         frame_start <= 1'b0;
         byte_valid  <= 1'b0;
         wr          <= 1'b0;
         status      <= '0;
      end else begin
         frame_start <= sfd_seen;
         byte_valid  <= byte_done;
         // Last slot is never written so the counter cannot wrap
         wr          <= byte_done && !(&byte_cnt);
         if (RX_DV) begin
            status.dv_detected <= 1'b1;
         end

         if (state == RX_IDLE) begin
            pre_cnt <= 3'd1;
         end else if (state == RX_PREAMBLE && pre_cnt != PRE_NIBBLES) begin
            pre_cnt <= pre_cnt + 3'd1;
         end

         if (sfd_seen) begin
            nib_hi     <= 1'b0;
            byte_cnt   <= '0;
            addr_own   <= 1'b1;
            addr_bcast <= 1'b1;
         end else if (state == eth_rx_pkg::RX_DATA && RX_DV && !closing) begin
            nib_hi <= !nib_hi;
         end

         if (byte_done) begin
            if (!(&byte_cnt)) begin
               byte_cnt <= byte_cnt + 1'b1;
            end
            if (!addr_done) begin
               addr_own   <= own_next;
               addr_bcast <= bcast_next;
            end
         end

         case (state)
            RX_IDLE: begin
               if (RX_DV && RX_DATA == 4'h5) begin
                  state <= RX_PREAMBLE;
               end
            end
            RX_PREAMBLE: begin
               if (sfd_seen) begin
                  state <= eth_rx_pkg::RX_DATA;
               end else if (!RX_DV || RX_DATA != 4'h5) begin
                  state <= RX_IDLE;
               end
            end
            eth_rx_pkg::RX_DATA: begin
               if (closing) begin
                  // Last byte is through the CRC by now
                  closing          <= 1'b0;
                  state            <= RX_HOLD;
                  status.data_rcvd <= 1'b1;
                  status.crc_ok    <= crc_good;
                  status.rcv_size  <= RCV_SIZE_W'(byte_cnt);
               end else if (!RX_DV) begin
                  if (addr_done) begin
                     closing <= 1'b1;
                  end else begin
                     state <= RX_IDLE;
                  end
               end else if (byte_done && byte_cnt == 5 && !(own_next || bcast_next)) begin
                  state <= RX_DROP;
               end
            end
            RX_DROP: begin
               if (!RX_DV) begin
                  state <= RX_IDLE;
               end
            end
            RX_HOLD: begin
               if (rcv_ack) begin
                  status.data_rcvd <= 1'b0;
                  // Skip the tail of a frame that is still on the wire
                  state <= RX_DV ? RX_DROP : RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (state == eth_rx_pkg::RX_DATA && !nib_hi) begin
         nib_lo <= RX_DATA;
      end
      if (byte_done) begin
         byte_data <= new_byte;
         wr_data   <= new_byte;
         wr_addr   <= byte_cnt;
      end
   end

   // Held frame stays untouched until the CPU acknowledges it
   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      state == RX_HOLD |-> !wr);

   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      wr |-> !(&wr_addr));

endmodule

//--- eth_rx_pkg.sv
package eth_rx_pkg;

   localparam int WB_ADR_W   = 10;
   localparam int RCV_SIZE_W = 11;

   // Wishbone classic request, master to slave
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [WB_ADR_W-1:0] adr;
      logic [3:0]          sel;
      logic [31:0]         dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_DATA,
      RX_DROP,
      RX_HOLD
   } rx_state_t;

   // Receiver report towards the register file
   typedef struct packed {
      logic                  data_rcvd;
      logic                  crc_ok;
      logic                  dv_detected;
      logic [RCV_SIZE_W-1:0] rcv_size;
   } frame_status_t;

   // Register word addresses
   typedef enum logic [WB_ADR_W-1:0] {
      REG_STATUS  = 10'd0,
      REG_RCVACK  = 10'd1,
      REG_SOFTRST = 10'd2,
      REG_DUMMY   = 10'd3,
      REG_CRC     = 10'd4
   } reg_addr_t;

   // Address bit that opens the receive buffer window
   localparam int BUF_SEL_BIT = 9;

   // STATUS bit layout
   localparam int ST_DATA_RCVD   = 0;
   localparam int ST_CRC_OK      = 1;
   localparam int ST_DV_DETECTED = 2;
   localparam int ST_SIZE_LSB    = 16;

   // Reflected CRC-32 register after a frame with a good FCS
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

endpackage
